//--- files.f
+incdir+verilog
verilog/ooo_pkg.sv
verilog/map_table.sv
verilog/rs_fu_config.sv
verilog/rs.sv
verilog/exec_units.sv
verilog/ooo_core_top.sv
dv/ooo_core_chk.sv
dv/ooo_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -f files.f --top-module ooo_core_tb \
    -Mdir build -o ooo_core_sim

./build/ooo_core_sim 2>&1 | tee build/sim.log

if grep -q "Simulation failed" build/sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" build/sim.log; then
    echo "The simulation stopped before its closing line"
    exit 1
fi
exit 0

//--- dv/ooo_core_tb.sv
`include "ooo_config.svh"

module ooo_core_tb;

    localparam logic [1:0] KIND_INSTR = 2'd0;
    localparam logic [1:0] KIND_CFG   = 2'd1;
    localparam logic [1:0] KIND_DRAIN = 2'd2;

    // Dispatch spacing of an instruction row
    localparam logic [1:0] GAP_RANDOM = 2'd0;
    localparam logic [1:0] GAP_NONE   = 2'd1;
    localparam logic [1:0] GAP_STRICT = 2'd2;

    // One table row; cfg rows carry the entry in dest and the class in mode[0]
    typedef struct packed {
        logic [1:0]        kind;
        ooo_pkg::op_e      op;
        ooo_pkg::reg_idx_t dest;
        ooo_pkg::reg_idx_t src1;
        ooo_pkg::reg_idx_t src2;
        ooo_pkg::data_t    imm;
        logic [1:0]        mode;
    } step_t;

    logic                                clock;
    logic                                reset;
    logic                                dispatch_valid;
    logic                                dispatch_ready;
    ooo_pkg::op_e                        dispatch_op;
    ooo_pkg::reg_idx_t                   dispatch_dest;
    ooo_pkg::reg_idx_t                   dispatch_src1;
    ooo_pkg::reg_idx_t                   dispatch_src2;
    ooo_pkg::data_t                      dispatch_imm;
    logic                                cfg_valid;
    logic [$clog2(`OOO_RS_ENTRIES)-1:0]  cfg_entry;
    ooo_pkg::fu_class_e                  cfg_class;
    ooo_pkg::reg_idx_t                   read_addr;
    ooo_pkg::data_t                      read_data;
    logic                                cdb_valid;
    ooo_pkg::tag_t                       cdb_tag;
    ooo_pkg::reg_idx_t                   cdb_dest;
    ooo_pkg::data_t                      cdb_value;
    logic                                idle;

    step_t             steps [$];
    ooo_pkg::data_t    model [`OOO_ARCH_REGS];
    // Results owed by dispatched instructions, in program-order values
    ooo_pkg::reg_idx_t pending_dest [$];
    ooo_pkg::data_t    pending_value [$];
    int                errors = 0;
    int                checks = 0;
    int                cdb_count = 0;
    int                prog_cdb_base = 0;
    int                prog_dispatched = 0;
    int                prog_stalls = 0;

    ooo_core_top dut (.*);

    always #50 clock = ~clock;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Each broadcast must retire exactly one owed result
    task automatic match_broadcast(input ooo_pkg::reg_idx_t dest, input ooo_pkg::data_t value);
        int hit;
        hit = -1;
        for (int i = 0; i < pending_dest.size(); i++) begin
            if (hit < 0 && pending_dest[i] == dest && pending_value[i] == value) begin
                hit = i;
            end
        end
        check_value(32'(hit >= 0), 32'd1,
                    $sformatf("broadcast of %0h to r%0d matches no dispatched instruction",
                              value, dest));
        if (hit >= 0) begin
            pending_dest.delete(hit);
            pending_value.delete(hit);
        end
    endtask

    // One count per broadcast cycle
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            cdb_count++;
            match_broadcast(cdb_dest, cdb_value);
        end
    end

    task automatic queue_instr(input ooo_pkg::op_e code, input int dest, input int src1,
                               input int src2, input ooo_pkg::data_t imm, input logic [1:0] mode);
        step_t s;
        s.kind = KIND_INSTR;
        s.op   = code;
        s.dest = ooo_pkg::reg_idx_t'(dest);
        s.src1 = ooo_pkg::reg_idx_t'(src1);
        s.src2 = ooo_pkg::reg_idx_t'(src2);
        s.imm  = imm;
        s.mode = mode;
        steps.push_back(s);
    endtask

    task automatic insert_cfg(input int entry, input ooo_pkg::fu_class_e cls);
        step_t s;
        s      = '0;
        s.kind = KIND_CFG;
        s.dest = ooo_pkg::reg_idx_t'(entry);
        s.mode = {1'b0, cls};
        steps.push_back(s);
    endtask

    task automatic mark_drain(input logic expect_stall);
        step_t s;
        s      = '0;
        s.kind = KIND_DRAIN;
        s.mode = {1'b0, expect_stall};
        steps.push_back(s);
    endtask

    task automatic build_program();
        // Plain ALU chains
        queue_instr(ooo_pkg::op_li,  1, 0, 0, 32'd5, GAP_RANDOM);
        queue_instr(ooo_pkg::op_li,  2, 0, 0, 32'h1234_5678, GAP_RANDOM);
        queue_instr(ooo_pkg::op_add, 3, 1, 2, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_sub, 4, 3, 1, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_xor, 5, 4, 2, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_add, 1, 1, 5, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_sub, 6, 1, 3, 0, GAP_RANDOM);
        mark_drain(1'b0);
        // Mul results feeding ALU ops and back
        queue_instr(ooo_pkg::op_li,  7, 0, 0, 32'd7, GAP_RANDOM);
        queue_instr(ooo_pkg::op_mul, 8, 7, 2, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_add, 9, 8, 1, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_mul, 10, 9, 9, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_xor, 11, 10, 8, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_sub, 12, 11, 7, 0, GAP_RANDOM);
        queue_instr(ooo_pkg::op_mul, 13, 12, 3, 0, GAP_RANDOM);
        mark_drain(1'b0);
        // Slow mul then fast add to the same register
        queue_instr(ooo_pkg::op_mul, 4, 2, 3, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_sub, 5, 4, 1, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_add, 4, 1, 2, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_xor, 6, 4, 5, 0, GAP_NONE);
        mark_drain(1'b0);
        // Five ALU ops and three muls behind one mul result
        queue_instr(ooo_pkg::op_li,  1, 0, 0, 32'd3, GAP_RANDOM);
        queue_instr(ooo_pkg::op_mul, 2, 1, 1, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_add, 3, 2, 1, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_add, 4, 2, 2, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_sub, 5, 2, 1, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_xor, 6, 2, 1, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_add, 7, 2, 3, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_mul, 8, 2, 1, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_mul, 9, 1, 1, 0, GAP_NONE);
        queue_instr(ooo_pkg::op_mul, 10, 9, 1, 0, GAP_NONE);
        mark_drain(1'b1);
        // The li result meets the mul result on the CDB
        queue_instr(ooo_pkg::op_mul, 8, 1, 2, 0, GAP_STRICT);
        queue_instr(ooo_pkg::op_xor, 9, 8, 3, 0, GAP_STRICT);
        queue_instr(ooo_pkg::op_li,  10, 0, 0, 32'hcafe_0042, GAP_STRICT);
        mark_drain(1'b0);
        // Four mul entries after moving entries 2 and 3
        insert_cfg(3, ooo_pkg::fu_mul);
        insert_cfg(2, ooo_pkg::fu_mul);
        queue_instr(ooo_pkg::op_mul, 11, 1, 2, 0, GAP_STRICT);
        queue_instr(ooo_pkg::op_mul, 12, 3, 4, 0, GAP_STRICT);
        queue_instr(ooo_pkg::op_mul, 13, 5, 6, 0, GAP_STRICT);
        queue_instr(ooo_pkg::op_mul, 14, 7, 8, 0, GAP_STRICT);
        queue_instr(ooo_pkg::op_add, 15, 11, 14, 0, GAP_RANDOM);
        mark_drain(1'b0);
    endtask

    // Sequential reference in program order
    task automatic run_model(input step_t s);
        case (s.op)
            ooo_pkg::op_add: model[s.dest] = model[s.src1] + model[s.src2];
            ooo_pkg::op_sub: model[s.dest] = model[s.src1] - model[s.src2];
            ooo_pkg::op_xor: model[s.dest] = model[s.src1] ^ model[s.src2];
            ooo_pkg::op_li:  model[s.dest] = s.imm;
            ooo_pkg::op_mul: model[s.dest] = model[s.src1] * model[s.src2];
            default: ;
        endcase
    endtask

    task automatic drive_instr(input step_t s);
        int gap;
        int waited;
        gap    = (s.mode == GAP_RANDOM) ? int'($urandom % 32'd3) : 0;
        waited = 0;
        dispatch_valid = 1'b0;
        repeat (gap) @(negedge clock);
        dispatch_valid = 1'b1;
        dispatch_op    = s.op;
        dispatch_dest  = s.dest;
        dispatch_src1  = s.src1;
        dispatch_src2  = s.src2;
        dispatch_imm   = s.imm;
        #1;
        while (!dispatch_ready) begin
            waited++;
            @(negedge clock);
            #1;
        end
        // Taken at the rising edge in between
        @(negedge clock);
        dispatch_valid = 1'b0;
        run_model(s);
        pending_dest.push_back(s.dest);
        pending_value.push_back(model[s.dest]);
        prog_dispatched++;
        prog_stalls += waited;
        if (s.mode == GAP_STRICT) begin
            check_value(waited, 0, "back-to-back dispatch was stalled");
        end
    endtask

    task automatic apply_cfg(input step_t s);
        cfg_valid = 1'b1;
        cfg_entry = s.dest[2:0];
        cfg_class = ooo_pkg::fu_class_e'(s.mode[0]);
        @(negedge clock);
        cfg_valid = 1'b0;
    endtask

    task automatic drain_and_check(input step_t s);
        #1;
        while (!idle) begin
            @(negedge clock);
            #1;
        end
        for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
            @(negedge clock);
            read_addr = ooo_pkg::reg_idx_t'(r);
            #1;
            check_value(read_data, model[r], $sformatf("register r%0d after drain", r));
        end
        check_value(cdb_count - prog_cdb_base, prog_dispatched, "CDB broadcast count");
        check_value(pending_dest.size(), 0, "results never broadcast");
        if (s.mode[0]) begin
            check_value(32'(prog_stalls != 0), 32'd1, "dispatch never stalled on a full class");
        end
        prog_cdb_base   = cdb_count;
        prog_dispatched = 0;
        prog_stalls     = 0;
        @(negedge clock);
    endtask

    initial begin
        void'($urandom(32'h418e41a2));
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = ooo_pkg::op_add;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_imm   = '0;
        cfg_valid      = 1'b0;
        cfg_entry      = '0;
        cfg_class      = ooo_pkg::fu_alu;
        read_addr      = '0;
        for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
            model[r] = '0;
        end
        build_program();
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        foreach (steps[i]) begin
            case (steps[i].kind)
                KIND_INSTR: drive_instr(steps[i]);
                KIND_CFG:   apply_cfg(steps[i]);
                default:    drain_and_check(steps[i]);
            endcase
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Twenty cycles per table row on top of the reset time
    initial begin
        int limit;
        #1;
        limit = steps.size() * 20 + 8;
        repeat (limit) @(posedge clock);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- dv/ooo_core_chk.sv
`include "ooo_config.svh"

module ooo_core_chk (
    input logic                        clock,
    input logic                        reset,
    input logic                        dispatch_valid,
    input logic                        dispatch_ready,
    input ooo_pkg::op_e                dispatch_op,
    input ooo_pkg::reg_idx_t           dispatch_dest,
    input ooo_pkg::reg_idx_t           dispatch_src1,
    input ooo_pkg::reg_idx_t           dispatch_src2,
    input ooo_pkg::data_t              dispatch_imm,
    input logic                        cdb_valid,
    input ooo_pkg::tag_t               cdb_tag,
    input logic                        idle,
    input logic [`OOO_RS_ENTRIES-1:0]  entry_busy
);

    logic [`OOO_RS_ENTRIES-1:0] busy_prev;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy_prev <= '0;
        end else begin
            busy_prev <= entry_busy;
        end
    end

    // A stalled request holds its payload
    dispatch_hold: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch_op)
            && $stable(dispatch_dest) && $stable(dispatch_src1) && $stable(dispatch_src2)
            && $stable(dispatch_imm))
        else $error("dispatch request changed while stalled");

    cdb_quiet_in_reset: assert property (@(posedge clock) reset |-> !cdb_valid)
        else $error("CDB active during reset");

    // Broadcast tag belongs to an entry that was already waiting
    cdb_from_busy: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> !idle && cdb_tag != '0 && busy_prev[cdb_tag - 3'd1])
        else $error("CDB broadcast for a free entry");

endmodule

bind ooo_core_top ooo_core_chk u_chk (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch_op    (dispatch_op),
    .dispatch_dest  (dispatch_dest),
    .dispatch_src1  (dispatch_src1),
    .dispatch_src2  (dispatch_src2),
    .dispatch_imm   (dispatch_imm),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .idle           (idle),
    .entry_busy     (entry_busy)
);

//--- verilog/ooo_core_top.sv
`include "ooo_config.svh"

module ooo_core_top (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                dispatch_valid,
    output logic                                dispatch_ready,
    input  ooo_pkg::op_e                        dispatch_op,
    input  ooo_pkg::reg_idx_t                   dispatch_dest,
    input  ooo_pkg::reg_idx_t                   dispatch_src1,
    input  ooo_pkg::reg_idx_t                   dispatch_src2,
    input  ooo_pkg::data_t                      dispatch_imm,
    input  logic                                cfg_valid,
    input  logic [$clog2(`OOO_RS_ENTRIES)-1:0]  cfg_entry,
    input  ooo_pkg::fu_class_e                  cfg_class,
    input  ooo_pkg::reg_idx_t                   read_addr,
    output ooo_pkg::data_t                      read_data,
    output logic                                cdb_valid,
    output ooo_pkg::tag_t                       cdb_tag,
    output ooo_pkg::reg_idx_t                   cdb_dest,
    output ooo_pkg::data_t                      cdb_value,
    output logic                                idle
);

    logic                        dispatch_fire;
    ooo_pkg::tag_t               alloc_tag;
    ooo_pkg::tag_t               src1_tag;
    ooo_pkg::tag_t               src2_tag;
    ooo_pkg::data_t              src1_value;
    ooo_pkg::data_t              src2_value;
    logic [`OOO_RS_ENTRIES-1:0]  entry_busy;
    ooo_pkg::fu_class_e          entry_class [`OOO_RS_ENTRIES];

    logic              alu_issue_valid;
    logic              alu_issue_ready;
    ooo_pkg::op_e      alu_issue_op;
    ooo_pkg::tag_t     alu_issue_tag;
    ooo_pkg::reg_idx_t alu_issue_dest;
    ooo_pkg::data_t    alu_issue_a;
    ooo_pkg::data_t    alu_issue_b;
    logic              mul_issue_valid;
    logic              mul_issue_ready;
    ooo_pkg::op_e      mul_issue_op;
    ooo_pkg::tag_t     mul_issue_tag;
    ooo_pkg::reg_idx_t mul_issue_dest;
    ooo_pkg::data_t    mul_issue_a;
    ooo_pkg::data_t    mul_issue_b;

    map_table u_map_table (.*);

    rs_fu_config u_rs_fu_config (.*);

    rs u_rs (.*);

    exec_units u_exec_units (.*);

endmodule

//--- verilog/exec_units.sv
`include "ooo_config.svh"

module exec_units (
    input  logic               clock,
    input  logic               reset,
    input  logic               alu_issue_valid,
    output logic               alu_issue_ready,
    input  ooo_pkg::op_e       alu_issue_op,
    input  ooo_pkg::tag_t      alu_issue_tag,
    input  ooo_pkg::reg_idx_t  alu_issue_dest,
    input  ooo_pkg::data_t     alu_issue_a,
    input  ooo_pkg::data_t     alu_issue_b,
    input  logic               mul_issue_valid,
    output logic               mul_issue_ready,
    input  ooo_pkg::op_e       mul_issue_op,
    input  ooo_pkg::tag_t      mul_issue_tag,
    input  ooo_pkg::reg_idx_t  mul_issue_dest,
    input  ooo_pkg::data_t     mul_issue_a,
    input  ooo_pkg::data_t     mul_issue_b,
    output logic               cdb_valid,
    output ooo_pkg::tag_t      cdb_tag,
    output ooo_pkg::reg_idx_t  cdb_dest,
    output ooo_pkg::data_t     cdb_value
);

    // ALU holding register
    logic              alu_valid;
    ooo_pkg::tag_t     alu_tag;
    ooo_pkg::reg_idx_t alu_dest;
    ooo_pkg::data_t    alu_value;
    ooo_pkg::data_t    alu_result;
    logic              alu_sent;

    // Multiplier pipeline, stage 3 drives the CDB
    logic [2:0]        mul_v;
    ooo_pkg::op_e      mul_op1;
    ooo_pkg::data_t    mul_a1;
    ooo_pkg::data_t    mul_b1;
    ooo_pkg::tag_t     mul_tag [3];
    ooo_pkg::reg_idx_t mul_dest [3];
    ooo_pkg::data_t    mul_p2;
    ooo_pkg::data_t    mul_p3;

    always_comb begin
        case (alu_issue_op)
            ooo_pkg::op_add: alu_result = alu_issue_a + alu_issue_b;
            ooo_pkg::op_sub: alu_result = alu_issue_a - alu_issue_b;
            ooo_pkg::op_xor: alu_result = alu_issue_a ^ alu_issue_b;
            ooo_pkg::op_li:  alu_result = alu_issue_b;
            default:         alu_result = '0;
        endcase
    end

    // The held result leaves only when the multiplier is not broadcasting
    assign alu_sent        = alu_valid && !mul_v[2];
    assign alu_issue_ready = !alu_valid || alu_sent;
    assign mul_issue_ready = 1'b1;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_valid <= 1'b0;
            mul_v     <= '0;
        end else begin
            if (alu_issue_valid && alu_issue_ready) begin
                alu_valid <= 1'b1;
            end else if (alu_sent) begin
                alu_valid <= 1'b0;
            end
            mul_v <= {mul_v[1:0], mul_issue_valid && mul_issue_ready};
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue_valid && alu_issue_ready) begin
            alu_tag   <= alu_issue_tag;
            alu_dest  <= alu_issue_dest;
            alu_value <= alu_result;
        end
        mul_op1     <= mul_issue_op;
        mul_a1      <= mul_issue_a;
        mul_b1      <= mul_issue_b;
        mul_tag[0]  <= mul_issue_tag;
        mul_dest[0] <= mul_issue_dest;
        // Low half of the product only
        mul_p2      <= (mul_op1 == ooo_pkg::op_mul) ? mul_a1 * mul_b1 : '0;
        mul_tag[1]  <= mul_tag[0];
        mul_dest[1] <= mul_dest[0];
        mul_p3      <= mul_p2;
        mul_tag[2]  <= mul_tag[1];
        mul_dest[2] <= mul_dest[1];
    end

    // Multiplier has fixed priority on the CDB
    assign cdb_valid = mul_v[2] || alu_valid;
    assign cdb_tag   = mul_v[2] ? mul_tag[2] : alu_tag;
    assign cdb_dest  = mul_v[2] ? mul_dest[2] : alu_dest;
    assign cdb_value = mul_v[2] ? mul_p3 : alu_value;

endmodule

//--- verilog/rs.sv
`include "ooo_config.svh"

module rs (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        dispatch_valid,
    output logic                        dispatch_ready,
    input  ooo_pkg::op_e                dispatch_op,
    input  ooo_pkg::reg_idx_t           dispatch_dest,
    input  ooo_pkg::data_t              dispatch_imm,
    input  ooo_pkg::tag_t               src1_tag,
    input  ooo_pkg::tag_t               src2_tag,
    input  ooo_pkg::data_t              src1_value,
    input  ooo_pkg::data_t              src2_value,
    output ooo_pkg::tag_t               alloc_tag,
    output logic                        dispatch_fire,
    input  ooo_pkg::fu_class_e          entry_class [`OOO_RS_ENTRIES],
    output logic [`OOO_RS_ENTRIES-1:0]  entry_busy,
    output logic                        alu_issue_valid,
    output logic                        mul_issue_valid,
    input  logic                        alu_issue_ready,
    input  logic                        mul_issue_ready,
    output ooo_pkg::op_e                alu_issue_op,
    output ooo_pkg::op_e                mul_issue_op,
    output ooo_pkg::tag_t               alu_issue_tag,
    output ooo_pkg::tag_t               mul_issue_tag,
    output ooo_pkg::reg_idx_t           alu_issue_dest,
    output ooo_pkg::reg_idx_t           mul_issue_dest,
    output ooo_pkg::data_t              alu_issue_a,
    output ooo_pkg::data_t              alu_issue_b,
    output ooo_pkg::data_t              mul_issue_a,
    output ooo_pkg::data_t              mul_issue_b,
    input  logic                        cdb_valid,
    input  ooo_pkg::tag_t               cdb_tag,
    input  ooo_pkg::data_t              cdb_value,
    output logic                        idle
);

    localparam int N     = `OOO_RS_ENTRIES;
    localparam int IDX_W = $clog2(N);

    logic [N-1:0]      busy;
    logic [N-1:0]      issued;
    logic [N-1:0]      ready;
    ooo_pkg::op_e      op   [N];
    ooo_pkg::reg_idx_t dest [N];
    ooo_pkg::tag_t     t1   [N];
    ooo_pkg::tag_t     t2   [N];
    ooo_pkg::data_t    v1   [N];
    ooo_pkg::data_t    v2   [N];

    ooo_pkg::fu_class_e need_class;
    ooo_pkg::tag_t      new_t1;
    ooo_pkg::tag_t      new_t2;
    ooo_pkg::data_t     new_v1;
    ooo_pkg::data_t     new_v2;

    logic             alu_found;
    logic             mul_found;
    logic [IDX_W-1:0] alu_sel;
    logic [IDX_W-1:0] mul_sel;
    logic             alu_fire;
    logic             mul_fire;

    assign need_class = (dispatch_op == ooo_pkg::op_mul) ? ooo_pkg::fu_mul : ooo_pkg::fu_alu;

    // Lowest free entry of the needed class, descending scan so the lowest wins
    always_comb begin
        dispatch_ready = 1'b0;
        alloc_tag      = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!busy[i] && entry_class[i] == need_class) begin
                dispatch_ready = 1'b1;
                alloc_tag      = ooo_pkg::tag_t'(i + 1);
            end
        end
    end

    assign dispatch_fire = dispatch_valid && dispatch_ready;

    // li carries its immediate as operand b, source 1 is ignored
    always_comb begin
        if (dispatch_op == ooo_pkg::op_li) begin
            new_t1 = '0;
            new_v1 = '0;
            new_t2 = '0;
            new_v2 = dispatch_imm;
        end else begin
            new_t1 = src1_tag;
            new_v1 = src1_value;
            new_t2 = src2_tag;
            new_v2 = src2_value;
        end
    end

    // Issue select per unit, lowest ready entry first
    always_comb begin
        alu_found = 1'b0;
        mul_found = 1'b0;
        alu_sel   = '0;
        mul_sel   = '0;
        for (int i = N - 1; i >= 0; i--) begin
            ready[i] = busy[i] && !issued[i] && t1[i] == '0 && t2[i] == '0;
            if (ready[i] && op[i] != ooo_pkg::op_mul) begin
                alu_found = 1'b1;
                alu_sel   = IDX_W'(i);
            end
            if (ready[i] && op[i] == ooo_pkg::op_mul) begin
                mul_found = 1'b1;
                mul_sel   = IDX_W'(i);
            end
        end
    end

    assign alu_issue_valid = alu_found;
    assign mul_issue_valid = mul_found;
    assign alu_fire        = alu_found && alu_issue_ready;
    assign mul_fire        = mul_found && mul_issue_ready;

    assign alu_issue_op   = op[alu_sel];
    assign alu_issue_tag  = ooo_pkg::tag_t'(alu_sel) + ooo_pkg::tag_t'(1);
    assign alu_issue_dest = dest[alu_sel];
    assign alu_issue_a    = v1[alu_sel];
    assign alu_issue_b    = v2[alu_sel];
    assign mul_issue_op   = op[mul_sel];
    assign mul_issue_tag  = ooo_pkg::tag_t'(mul_sel) + ooo_pkg::tag_t'(1);
    assign mul_issue_dest = dest[mul_sel];
    assign mul_issue_a    = v1[mul_sel];
    assign mul_issue_b    = v2[mul_sel];

    // Entry control: allocate, issue, wakeup and free on own broadcast
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
            for (int i = 0; i < N; i++) begin
                t1[i] <= '0;
                t2[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (dispatch_fire && alloc_tag == ooo_pkg::tag_t'(i + 1)) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                    t1[i]     <= new_t1;
                    t2[i]     <= new_t2;
                end else if (busy[i]) begin
                    if ((alu_fire && int'(alu_sel) == i) || (mul_fire && int'(mul_sel) == i)) begin
                        issued[i] <= 1'b1;
                    end
                    if (cdb_valid && t1[i] != '0 && t1[i] == cdb_tag) begin
                        t1[i] <= '0;
                    end
                    if (cdb_valid && t2[i] != '0 && t2[i] == cdb_tag) begin
                        t2[i] <= '0;
                    end
                    if (cdb_valid && cdb_tag == ooo_pkg::tag_t'(i + 1)) begin
                        busy[i]   <= 1'b0;
                        issued[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // Entry payload and operand capture
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (dispatch_fire && alloc_tag == ooo_pkg::tag_t'(i + 1)) begin
                op[i]   <= dispatch_op;
                dest[i] <= dispatch_dest;
                v1[i]   <= new_v1;
                v2[i]   <= new_v2;
            end else begin
                if (cdb_valid && t1[i] != '0 && t1[i] == cdb_tag) begin
                    v1[i] <= cdb_value;
                end
                if (cdb_valid && t2[i] != '0 && t2[i] == cdb_tag) begin
                    v2[i] <= cdb_value;
                end
            end
        end
    end

    assign entry_busy = busy;
    assign idle       = busy == '0;

endmodule

//--- verilog/rs_fu_config.sv
`include "ooo_config.svh"

module rs_fu_config (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 cfg_valid,
    input  logic [$clog2(`OOO_RS_ENTRIES)-1:0]   cfg_entry,
    input  ooo_pkg::fu_class_e                   cfg_class,
    input  logic [`OOO_RS_ENTRIES-1:0]           entry_busy,
    output ooo_pkg::fu_class_e                   entry_class [`OOO_RS_ENTRIES]
);

    // Last two entries serve the multiplier by default
    localparam int ALU_DEFAULT = `OOO_RS_ENTRIES - 2;

    ooo_pkg::fu_class_e class_q [`OOO_RS_ENTRIES];
    logic               cfg_accept;

    // Ignore writes outside the station and writes to a waiting entry
    always_comb begin
        cfg_accept = 1'b0;
        if (cfg_valid && int'(cfg_entry) < `OOO_RS_ENTRIES) begin
            cfg_accept = !entry_busy[cfg_entry];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `OOO_RS_ENTRIES; i++) begin
                if (i < ALU_DEFAULT) begin
                    class_q[i] <= ooo_pkg::fu_alu;
                end else begin
                    class_q[i] <= ooo_pkg::fu_mul;
                end
            end
        end else if (cfg_accept) begin
            class_q[cfg_entry] <= cfg_class;
        end
    end

    always_comb begin
        for (int i = 0; i < `OOO_RS_ENTRIES; i++) begin
            entry_class[i] = class_q[i];
        end
    end

endmodule

//--- verilog/map_table.sv
`include "ooo_config.svh"

module map_table (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_fire,
    input  ooo_pkg::reg_idx_t  dispatch_dest,
    input  ooo_pkg::reg_idx_t  dispatch_src1,
    input  ooo_pkg::reg_idx_t  dispatch_src2,
    input  ooo_pkg::tag_t      alloc_tag,
    output ooo_pkg::tag_t      src1_tag,
    output ooo_pkg::tag_t      src2_tag,
    output ooo_pkg::data_t     src1_value,
    output ooo_pkg::data_t     src2_value,
    input  logic               cdb_valid,
    input  ooo_pkg::tag_t      cdb_tag,
    input  ooo_pkg::reg_idx_t  cdb_dest,
    input  ooo_pkg::data_t     cdb_value,
    input  ooo_pkg::reg_idx_t  read_addr,
    output ooo_pkg::data_t     read_data
);

    ooo_pkg::data_t regs [`OOO_ARCH_REGS];
    ooo_pkg::tag_t  tags [`OOO_ARCH_REGS];

    logic cdb_commit;

    // Only the current producer of a register may commit into it
    assign cdb_commit = cdb_valid && tags[cdb_dest] == cdb_tag;

    // Source lookup with bypass of a broadcast in the same cycle
    always_comb begin
        src1_tag   = tags[dispatch_src1];
        src1_value = regs[dispatch_src1];
        if (src1_tag != '0 && cdb_valid && cdb_tag == src1_tag) begin
            src1_tag   = '0;
            src1_value = cdb_value;
        end
        src2_tag   = tags[dispatch_src2];
        src2_value = regs[dispatch_src2];
        if (src2_tag != '0 && cdb_valid && cdb_tag == src2_tag) begin
            src2_tag   = '0;
            src2_value = cdb_value;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (cdb_commit) begin
                regs[cdb_dest] <= cdb_value;
                tags[cdb_dest] <= '0;
            end
            // A new rename overrides the retire of the older producer
            if (dispatch_fire) begin
                tags[dispatch_dest] <= alloc_tag;
            end
        end
    end

    assign read_data = regs[read_addr];

endmodule

//--- verilog/ooo_pkg.sv
`include "ooo_config.svh"

package ooo_pkg;

    // Data word on the operand and result paths
    typedef logic [`OOO_DATA_WIDTH-1:0] data_t;

    // Producer tag, zero when the value is already present
    typedef logic [`OOO_TAG_WIDTH-1:0] tag_t;

    // Architectural register index
    typedef logic [`OOO_REG_WIDTH-1:0] reg_idx_t;

    // Integer opcodes handled by the core
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_li,
        op_mul
    } op_e;

    // Functional-unit class of a station entry
    typedef enum logic {
        fu_alu,
        fu_mul
    } fu_class_e;

endpackage

//--- verilog/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// Reservation-station entries, tag = entry number + 1
`define OOO_RS_ENTRIES 6

// Architectural register file
`define OOO_ARCH_REGS 16

// Datapath width
`define OOO_DATA_WIDTH 32

// Producer tag width, tag zero means value present
`define OOO_TAG_WIDTH 3

// Architectural register index width
`define OOO_REG_WIDTH 4

`endif
